//--- hw/rv_core_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Integer register and data path width.
`define RV_XLEN 64

// Data memory holds 64-bit words.
`define RV_DMEM_WORDS 256

// Word index width, log2 of RV_DMEM_WORDS.
`define RV_DMEM_AW 8

// Integer register count, x0 included.
`define RV_NREGS 32

`endif

//--- hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Major opcodes seen at the memory stage.
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LD  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        LWU = 3'b110
    } ld_funct3_e;

    typedef enum logic [2:0] {
        SB = 3'b000,
        SH = 3'b001,
        SW = 3'b010,
        SD = 3'b011
    } st_funct3_e;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    // Immediate split around rs2 and rs1.
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef union packed {
        i_fmt_t      i_fmt;
        s_fmt_t      s_fmt;
        logic [31:0] raw;
    } ldst_inst_u;

endpackage

`default_nettype wire

//--- hw/rv_pipe_pkg.sv
`default_nettype none

`include "rv_core_macros.svh"

package rv_pipe_pkg;

    // Register write request toward writeback.
    typedef struct packed {
        logic                we;
        logic [4:0]          waddr;
        logic [`RV_XLEN-1:0] wdata;
    } wb_req_t;

    // Machine CSR snapshot for trace comparison.
    typedef struct packed {
        logic [`RV_XLEN-1:0] mtvec;
        logic [`RV_XLEN-1:0] mepc;
        logic [`RV_XLEN-1:0] mstatus;
        logic [`RV_XLEN-1:0] mcause;
    } csr_snap_t;

    // Execute stage output. csr_snap order is mtvec, mepc, mstatus, mcause.
    typedef struct packed {
        logic                      commit;
        logic [`RV_XLEN-1:0]       pc;
        logic [31:0]               inst;
        logic [`RV_XLEN-1:0]       alu_result;
        logic [`RV_XLEN-1:0]       csr_rdata;
        logic                      csr_sel;
        logic [`RV_XLEN-1:0]       rs1_val;
        logic [`RV_XLEN-1:0]       rs2_val;
        logic                      exu_we;
        logic [3:0][`RV_XLEN-1:0]  csr_snap;
    } exu_pkt_t;

    // Retired instruction with the write it caused.
    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         inst;
        wb_req_t             wb;
    } commit_t;

endpackage

`default_nettype wire

//--- hw/lsu_stage.sv
`default_nettype none

`include "rv_core_macros.svh"

module lsu_stage (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire rv_pipe_pkg::exu_pkt_t pkt_i,
    output logic                      ld_we_o,
    output logic [4:0]                ld_waddr_o,
    output logic [`RV_XLEN-1:0]       ld_wdata_o
);

    localparam int NBYTES = `RV_XLEN / 8;

    rv_isa_pkg::ldst_inst_u   inst_u;
    logic                     is_load;
    logic                     is_store;
    logic                     st_en;
    logic [`RV_XLEN-1:0]      imm_sext;
    logic [`RV_XLEN-1:0]      eff_addr;
    logic [`RV_DMEM_AW-1:0]   word_idx;
    logic [2:0]               byte_off;
    logic [`RV_XLEN-1:0]      rd_word;
    logic [`RV_XLEN-1:0]      rd_shift;
    logic [NBYTES-1:0]        st_mask;
    logic [`RV_XLEN-1:0]      st_data;

    logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];

    assign inst_u.raw = pkt_i.inst;
    assign is_load    = (inst_u.i_fmt.opcode == rv_isa_pkg::LOAD);
    assign is_store   = (inst_u.s_fmt.opcode == rv_isa_pkg::STORE);

    // Immediate layout depends on the format.
    always_comb begin
        if (is_store) begin
            imm_sext = {{(`RV_XLEN-12){inst_u.s_fmt.imm_hi[6]}},
                        inst_u.s_fmt.imm_hi, inst_u.s_fmt.imm_lo};
        end else begin
            imm_sext = {{(`RV_XLEN-12){inst_u.i_fmt.imm[11]}}, inst_u.i_fmt.imm};
        end
    end

    assign eff_addr = pkt_i.rs1_val + imm_sext;
    assign word_idx = eff_addr[3 +: `RV_DMEM_AW];
    assign byte_off = eff_addr[2:0];

    // Old word, so a load never sees this cycle's store.
    assign rd_word  = dmem[word_idx];
    assign rd_shift = rd_word >> {byte_off, 3'b000};

    always_comb begin
        case (rv_isa_pkg::ld_funct3_e'(inst_u.i_fmt.funct3))
            rv_isa_pkg::LB:  ld_wdata_o = {{(`RV_XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
            rv_isa_pkg::LH:  ld_wdata_o = {{(`RV_XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
            rv_isa_pkg::LW:  ld_wdata_o = {{(`RV_XLEN-32){rd_shift[31]}}, rd_shift[31:0]};
            rv_isa_pkg::LBU: ld_wdata_o = {{(`RV_XLEN-8){1'b0}}, rd_shift[7:0]};
            rv_isa_pkg::LHU: ld_wdata_o = {{(`RV_XLEN-16){1'b0}}, rd_shift[15:0]};
            rv_isa_pkg::LWU: ld_wdata_o = {{(`RV_XLEN-32){1'b0}}, rd_shift[31:0]};
            default:         ld_wdata_o = rd_shift;
        endcase
    end

    assign ld_we_o    = is_load;
    assign ld_waddr_o = inst_u.i_fmt.rd;

    // Byte lanes past the end of the word are dropped.
    always_comb begin
        case (rv_isa_pkg::st_funct3_e'(inst_u.s_fmt.funct3))
            rv_isa_pkg::SB: st_mask = NBYTES'(8'h01) << byte_off;
            rv_isa_pkg::SH: st_mask = NBYTES'(8'h03) << byte_off;
            rv_isa_pkg::SW: st_mask = NBYTES'(8'h0f) << byte_off;
            rv_isa_pkg::SD: st_mask = NBYTES'(8'hff) << byte_off;
            default:        st_mask = '0;
        endcase
    end

    assign st_data = pkt_i.rs2_val << {byte_off, 3'b000};
    assign st_en   = is_store && pkt_i.commit && !rst_n;

    always_ff @(posedge clk) begin
        if (st_en) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (st_mask[b]) begin
                    dmem[word_idx][8*b +: 8] <= st_data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_wb_reg.sv
`default_nettype none

`include "rv_core_macros.svh"

module mem_wb_reg (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire rv_pipe_pkg::exu_pkt_t pkt_i,
    input  wire                        ld_we_i,
    input  wire [4:0]                  ld_waddr_i,
    input  wire [`RV_XLEN-1:0]         ld_wdata_i,
    output rv_pipe_pkg::wb_req_t       wb_o,
    output rv_pipe_pkg::commit_t       commit_o,
    output rv_pipe_pkg::csr_snap_t     csr_snap_o
);

    rv_pipe_pkg::wb_req_t wb_next;

    // Execute result wins over load data.
    always_comb begin
        wb_next = '0;
        if (pkt_i.exu_we) begin
            wb_next.we    = pkt_i.commit;
            wb_next.waddr = pkt_i.inst[11:7];
            wb_next.wdata = pkt_i.csr_sel ? pkt_i.csr_rdata : pkt_i.alu_result;
        end else if (ld_we_i) begin
            wb_next.we    = pkt_i.commit;
            wb_next.waddr = ld_waddr_i;
            wb_next.wdata = ld_wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            commit_o   <= '0;
            csr_snap_o <= '0;
        end else begin
            commit_o.valid     <= pkt_i.commit;
            commit_o.pc        <= pkt_i.pc;
            commit_o.inst      <= pkt_i.inst;
            commit_o.wb        <= wb_next;
            csr_snap_o.mtvec   <= pkt_i.csr_snap[0];
            csr_snap_o.mepc    <= pkt_i.csr_snap[1];
            csr_snap_o.mstatus <= pkt_i.csr_snap[2];
            csr_snap_o.mcause  <= pkt_i.csr_snap[3];
        end
    end

    // Same registered request goes on to the register file.
    assign wb_o = commit_o.wb;

endmodule

`default_nettype wire

//--- hw/wb_regfile.sv
`default_nettype none

`include "rv_core_macros.svh"

module wb_regfile (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire rv_pipe_pkg::wb_req_t wb_i,
    input  wire [4:0]                 raddr_i,
    output logic [`RV_XLEN-1:0]       rdata_o
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.waddr != 5'd0)) begin
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    // x0 reads as zero.
    assign rdata_o = (raddr_i == 5'd0) ? '0 : regs[raddr_i];

endmodule

`default_nettype wire

//--- hw/mem_wb_top.sv
`default_nettype none

`include "rv_core_macros.svh"

module mem_wb_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire rv_pipe_pkg::exu_pkt_t exu_pkt_i,
    input  wire [4:0]                  rf_raddr_i,
    output rv_pipe_pkg::commit_t       commit_o,
    output rv_pipe_pkg::csr_snap_t     csr_snap_o,
    output logic [`RV_XLEN-1:0]        rf_rdata_o
);

    logic                 lsu_we;
    logic [4:0]           lsu_waddr;
    logic [`RV_XLEN-1:0]  lsu_wdata;
    rv_pipe_pkg::wb_req_t wb_req;

    lsu_stage u_lsu (
        .clk        (clk),
        .rst_n      (rst_n),
        .pkt_i      (exu_pkt_i),
        .ld_we_o    (lsu_we),
        .ld_waddr_o (lsu_waddr),
        .ld_wdata_o (lsu_wdata)
    );

    mem_wb_reg u_mem_wb (
        .clk        (clk),
        .rst_n      (rst_n),
        .pkt_i      (exu_pkt_i),
        .ld_we_i    (lsu_we),
        .ld_waddr_i (lsu_waddr),
        .ld_wdata_i (lsu_wdata),
        .wb_o       (wb_req),
        .commit_o   (commit_o),
        .csr_snap_o (csr_snap_o)
    );

    wb_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_i    (wb_req),
        .raddr_i (rf_raddr_i),
        .rdata_o (rf_rdata_o)
    );

endmodule

`default_nettype wire

//--- tests/mem_wb_properties.sv
`default_nettype none

module mem_wb_properties (
    input wire                         clk,
    input wire                         rst_n,
    input wire rv_pipe_pkg::exu_pkt_t  pkt_i,
    input wire rv_pipe_pkg::wb_req_t   wb_o,
    input wire rv_pipe_pkg::commit_t   commit_o,
    input wire rv_pipe_pkg::csr_snap_t csr_snap_o
);

    // Reset is active high on rst_n.
    a_reset_clears: assert property (@(posedge clk)
        rst_n |=> (commit_o == '0 && csr_snap_o == '0))
        else $error("outputs not cleared after reset");

    a_we_needs_commit: assert property (@(posedge clk)
        wb_o.we |-> commit_o.valid)
        else $error("writeback enable without commit");

    a_pc_follows: assert property (@(posedge clk) disable iff (rst_n)
        !rst_n |=> (commit_o.pc == $past(pkt_i.pc)))
        else $error("commit pc differs from previous input pc");

endmodule

bind mem_wb_reg mem_wb_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .pkt_i      (pkt_i),
    .wb_o       (wb_o),
    .commit_o   (commit_o),
    .csr_snap_o (csr_snap_o)
);

`default_nettype wire

//--- tests/mem_wb_tb.sv
`default_nettype none

`include "rv_core_macros.svh"

module mem_wb_tb;

    localparam int N_RAND   = 16;
    localparam int MEM_SIZE = `RV_DMEM_WORDS * 8;

    logic                          clk;
    logic                          rst_n;
    rv_pipe_pkg::exu_pkt_t         exu_pkt_i;
    logic [4:0]                    rf_raddr_i;
    rv_pipe_pkg::commit_t          commit_o;
    rv_pipe_pkg::csr_snap_t        csr_snap_o;
    logic [`RV_XLEN-1:0]           rf_rdata_o;

    rv_pipe_pkg::exu_pkt_t         pkts[$];
    rv_pipe_pkg::wb_req_t          exp_q[$];
    logic [`RV_XLEN-1:0]           file_wdata[$];
    bit                            has_file[$];
    logic [7:0]                    mem_model [MEM_SIZE];
    logic [`RV_XLEN-1:0]           reg_model [`RV_NREGS];
    logic [31:0]                   rng_state = 32'h93c1_f2d1;
    int                            checks = 0;
    int                            errors = 0;
    int                            cycles = 0;
    int                            limit = 0;

    mem_wb_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .exu_pkt_i  (exu_pkt_i),
        .rf_raddr_i (rf_raddr_i),
        .commit_o   (commit_o),
        .csr_snap_o (csr_snap_o),
        .rf_rdata_o (rf_rdata_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the run went past %0d cycles without finishing", limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [63:0] next_rand64();
        logic [63:0] v;
        rng_state = xorshift32(rng_state);
        v[63:32] = rng_state;
        rng_state = xorshift32(rng_state);
        v[31:0] = rng_state;
        return v;
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // Byte-level load from the memory model, little endian.
    function automatic logic [63:0] model_load(input rv_pipe_pkg::exu_pkt_t p);
        logic [63:0] addr;
        logic [63:0] raw;
        int          base;
        int          off;
        addr = p.rs1_val + {{52{p.inst[31]}}, p.inst[31:20]};
        base = int'(addr[10:3]) * 8;
        off  = int'(addr[2:0]);
        raw  = '0;
        for (int i = 0; i < 8; i++) begin
            if (off + i < 8) begin
                raw[8*i +: 8] = mem_model[base + off + i];
            end
        end
        case (p.inst[14:12])
            3'b000:  return {{56{raw[7]}}, raw[7:0]};
            3'b001:  return {{48{raw[15]}}, raw[15:0]};
            3'b010:  return {{32{raw[31]}}, raw[31:0]};
            3'b100:  return {56'd0, raw[7:0]};
            3'b101:  return {48'd0, raw[15:0]};
            3'b110:  return {32'd0, raw[31:0]};
            default: return raw;
        endcase
    endfunction

    task automatic model_store(input rv_pipe_pkg::exu_pkt_t p);
        logic [63:0] addr;
        int          base;
        int          off;
        int          size;
        addr = p.rs1_val + {{52{p.inst[31]}}, p.inst[31:25], p.inst[11:7]};
        base = int'(addr[10:3]) * 8;
        off  = int'(addr[2:0]);
        size = 1 << p.inst[13:12];
        for (int b = 0; b < size; b++) begin
            if (off + b < 8) begin
                mem_model[base + off + b] = p.rs2_val[8*b +: 8];
            end
        end
    endtask

    // Execute write first, then a load, otherwise nothing.
    function automatic rv_pipe_pkg::wb_req_t expected_wb(input rv_pipe_pkg::exu_pkt_t p);
        rv_pipe_pkg::wb_req_t w;
        w = '0;
        if (p.exu_we) begin
            w.we    = p.commit;
            w.waddr = p.inst[11:7];
            w.wdata = p.csr_sel ? p.csr_rdata : p.alu_result;
        end else if (p.inst[6:0] == 7'b0000011) begin
            w.we    = p.commit;
            w.waddr = p.inst[11:7];
            w.wdata = model_load(p);
        end
        return w;
    endfunction

    task automatic check_commit(input int j);
        rv_pipe_pkg::exu_pkt_t p;
        rv_pipe_pkg::wb_req_t  w;
        p = pkts[j];
        w = exp_q[j];
        check_val("commit_o.valid", 64'(p.commit), 64'(commit_o.valid));
        check_val("commit_o.pc", p.pc, commit_o.pc);
        check_val("commit_o.inst", 64'(p.inst), 64'(commit_o.inst));
        check_val("commit_o.wb.we", 64'(w.we), 64'(commit_o.wb.we));
        check_val("commit_o.wb.waddr", 64'(w.waddr), 64'(commit_o.wb.waddr));
        check_val("commit_o.wb.wdata", w.wdata, commit_o.wb.wdata);
        if (has_file[j]) begin
            check_val("commit_o.wb.wdata (file)", file_wdata[j], commit_o.wb.wdata);
        end
        check_val("csr_snap_o.mtvec", p.csr_snap[0], csr_snap_o.mtvec);
        check_val("csr_snap_o.mepc", p.csr_snap[1], csr_snap_o.mepc);
        check_val("csr_snap_o.mstatus", p.csr_snap[2], csr_snap_o.mstatus);
        check_val("csr_snap_o.mcause", p.csr_snap[3], csr_snap_o.mcause);
    endtask

    task automatic read_stimulus(output int n_lines);
        int                    fd;
        int                    n;
        string                 line;
        logic [63:0]           f [9];
        rv_pipe_pkg::exu_pkt_t p;
        n_lines = 0;
        fd = $fopen("tests/mem_wb_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tests/mem_wb_stimulus.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                    if (n == 9) begin
                        p            = '0;
                        p.commit     = f[0][0];
                        p.exu_we     = f[1][0];
                        p.csr_sel    = f[2][0];
                        p.inst       = f[3][31:0];
                        p.rs1_val    = f[4];
                        p.rs2_val    = f[5];
                        p.alu_result = f[6];
                        p.csr_rdata  = f[7];
                        pkts.push_back(p);
                        file_wdata.push_back(f[8]);
                        has_file.push_back(1'b1);
                        n_lines++;
                    end else begin
                        errors++;
                        $display("Stimulus line could not be parsed: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int                    n_file;
        int                    total;
        logic [63:0]           r;
        rv_pipe_pkg::exu_pkt_t p;

        clk        = 1'b0;
        rst_n      = 1'b1;
        exu_pkt_i  = '0;
        rf_raddr_i = 5'd0;
        for (int i = 0; i < `RV_NREGS; i++) begin
            reg_model[i] = '0;
        end

        read_stimulus(n_file);
        // Random ALU packets after the directed ones.
        for (int i = 0; i < N_RAND; i++) begin
            r            = next_rand64();
            p            = '0;
            p.commit     = (r[9:8] != 2'b00);
            p.exu_we     = 1'b1;
            p.inst       = {r[31:20], 5'd0, 3'b000, r[4:0], 7'b0010011};
            p.alu_result = next_rand64();
            pkts.push_back(p);
            file_wdata.push_back('0);
            has_file.push_back(1'b0);
        end
        total = pkts.size();
        for (int i = 0; i < total; i++) begin
            pkts[i].pc = 64'h8000_0000 + 64'(4 * i);
            for (int c = 0; c < 4; c++) begin
                pkts[i].csr_snap[c] = next_rand64();
            end
        end
        limit = (n_file + N_RAND + 20) * 2;

        repeat (4) @(negedge clk);
        rst_n = 1'b0;
        check_val("commit_o.valid after reset", 64'd0, 64'(commit_o.valid));
        check_val("commit_o.pc after reset", 64'd0, commit_o.pc);
        check_val("commit_o.inst after reset", 64'd0, 64'(commit_o.inst));
        check_val("commit_o.wb.we after reset", 64'd0, 64'(commit_o.wb.we));
        check_val("commit_o.wb.waddr after reset", 64'd0, 64'(commit_o.wb.waddr));
        check_val("commit_o.wb.wdata after reset", 64'd0, commit_o.wb.wdata);
        check_val("csr_snap_o.mtvec after reset", 64'd0, csr_snap_o.mtvec);
        check_val("csr_snap_o.mepc after reset", 64'd0, csr_snap_o.mepc);
        check_val("csr_snap_o.mstatus after reset", 64'd0, csr_snap_o.mstatus);
        check_val("csr_snap_o.mcause after reset", 64'd0, csr_snap_o.mcause);
        // One register per cycle.
        for (int a = 0; a < `RV_NREGS; a++) begin
            rf_raddr_i = 5'(a);
            #5;
            check_val("rf_rdata_o after reset", 64'd0, rf_rdata_o);
            @(negedge clk);
        end

        for (int k = 0; k < total + 2; k++) begin
            @(negedge clk);
            if (k >= 2 && exp_q[k-2].we && exp_q[k-2].waddr != 5'd0) begin
                reg_model[exp_q[k-2].waddr] = exp_q[k-2].wdata;
            end
            if (k < total) begin
                exp_q.push_back(expected_wb(pkts[k]));
                if (pkts[k].commit && pkts[k].inst[6:0] == 7'b0100011) begin
                    model_store(pkts[k]);
                end
                exu_pkt_i = pkts[k];
            end else begin
                exu_pkt_i = '0;
            end
            if (k >= 2 && exp_q[k-2].we) begin
                rf_raddr_i = exp_q[k-2].waddr;
            end else begin
                rf_raddr_i = 5'(k);
            end
            #5;
            if (k >= 1 && k <= total) begin
                check_commit(k - 1);
            end
            check_val("rf_rdata_o", reg_model[rf_raddr_i], rf_rdata_o);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/mem_wb_stimulus.txt
# commit exu_we csr_sel inst rs1_val rs2_val alu_result csr_rdata exp_wdata
# All values hex. pc and CSR snapshot are generated by the testbench.
1 1 0 00000293 0 0 123456789abcdef0 0 123456789abcdef0
1 1 1 30002373 0 0 000000000000dead 0000000a00001800 0000000a00001800
0 1 0 00000393 0 0 5555 0 5555
1 1 0 00000013 0 0 777 0 777
1 0 0 0020b023 100 8877665544332211 0 0 0
1 0 0 0020b023 108 f0e0d0c0b0a09080 0 0 0
1 0 0 fe20ac23 118 0000000089abcdef 0 0 0
1 0 0 00209223 110 000000000000fe01 0 0 0
1 0 0 00208323 110 80 0 0 0
1 0 0 002083a3 110 7f 0 0 0
1 0 0 0000b503 100 0 0 0 8877665544332211
1 0 0 00808583 100 0 0 0 ffffffffffffff80
1 0 0 0080c603 100 0 0 0 80
1 0 0 ffe09683 118 0 0 0 7f80
1 0 0 00409703 110 0 0 0 fffffffffffffe01
1 0 0 0040d783 110 0 0 0 fe01
1 0 0 0000a803 110 0 0 0 ffffffff89abcdef
1 0 0 0000e883 110 0 0 0 89abcdef
1 0 0 ffc0a903 10c 0 0 0 ffffffffb0a09080
1 0 0 00508983 100 0 0 0 66
1 0 0 ff80bb03 118 0 0 0 7f80fe0189abcdef
0 0 0 0000ba03 100 0 0 0 8877665544332211
0 0 0 0020b023 100 deadbeefdeadbeef 0 0 0
1 0 0 0000ba83 100 0 0 0 8877665544332211

//--- project.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/lsu_stage.sv
hw/mem_wb_reg.sv
hw/wb_regfile.sv
hw/mem_wb_top.sv
tests/mem_wb_properties.sv
tests/mem_wb_tb.sv

//--- Bender.yml
package:
  name: mem_wb

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_isa_pkg.sv
      - hw/rv_pipe_pkg.sv
      - hw/lsu_stage.sv
      - hw/mem_wb_reg.sv
      - hw/wb_regfile.sv
      - hw/mem_wb_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/mem_wb_properties.sv
      - tests/mem_wb_tb.sv
